// File: Bender.yml
package:
  name: masterExternal

sources:
  - common/masterPkg.sv
  - busTransfer/arbiterLink.sv
  - busTransfer/frameShifter.sv
  - busTransfer/busTransfer.sv
  - rtl/sessionControl.sv
  - rtl/masterExternal.sv
  - target: simulation
    files:
      - sim/busModels.sv
      - sim/tbMasterExternal.sv

export_include_dirs: []

dependencies: {}

// File: busTransfer/arbiterLink.sv
`timescale 1ns/1ps

module arbiterLink import masterPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic arbCont,
    input  logic linkGo,
    input  logic linkRelease,
    output logic busFree,
    output logic linkDone,
    output logic arbSend
);

    linkState state;
    logic [1:0] arbSync;                 // two-flop synchronizer
    logic [linkCntWidth-1:0] cnt;        // shared by all three sequences
    logic [reqLen-1:0] reqShift;
    logic granted;

    assign granted = &arbSync;           // high on two consecutive samples
    assign busFree = ~arbSync[1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= lIdle;
            arbSync  <= '0;
            cnt      <= '0;
            reqShift <= '0;
            linkDone <= 1'b0;
            arbSend  <= 1'b0;
        end else begin
            arbSync  <= {arbSync[0], arbCont};
            linkDone <= 1'b0;
            case (state)
                lIdle: begin
                    // arbSend keeps its level between sequences
                    if (linkGo) begin
                        reqShift <= reqPattern;
                        cnt      <= '0;
                        state    <= lRequest;
                    end else if (linkRelease) begin
                        cnt   <= '0;
                        state <= lRelease;
                    end
                end
                lRequest: begin
                    arbSend  <= reqShift[reqLen-1];    // MSB first
                    reqShift <= reqShift << 1;
                    cnt      <= cnt + 1'b1;
                    if (cnt == linkCntWidth'(reqLen - 1)) begin
                        state <= lWaitGrant;
                    end
                end
                lWaitGrant: begin
                    if (granted) begin
                        arbSend <= 1'b1;    // first ack bit
                        cnt     <= '0;
                        state   <= lAck;
                    end
                end
                lAck: begin
                    // 0 then 1, then stay high for the gap
                    arbSend <= (cnt != '0);
                    cnt     <= cnt + 1'b1;
                    if (cnt == linkCntWidth'(ackGap + 1)) begin
                        linkDone <= 1'b1;
                        state    <= lIdle;
                    end
                end
                lRelease: begin
                    arbSend <= (cnt == linkCntWidth'(1)) || (cnt == linkCntWidth'(2));
                    cnt     <= cnt + 1'b1;
                    if (cnt == linkCntWidth'(3)) begin    // 0, 1, 1, then low
                        linkDone <= 1'b1;
                        state    <= lIdle;
                    end
                end
                default: state <= lIdle;
            endcase
        end
    end

endmodule

// File: busTransfer/busTransfer.sv
`timescale 1ns/1ps

module busTransfer import masterPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  xferReq req,
    input  logic   arbCont,
    input  logic   rD,
    input  logic   ready,
    output logic   xferReady,
    output xferRsp rsp,
    output logic   arbSend,
    output logic   control,
    output logic   wrD,
    output logic   valid
);

    commState state;
    logic writeReg;                  // direction of the transaction in flight
    logic [dataWidth-1:0] wordReg;
    logic accept;
    logic rspValid;

    // link handshake
    logic busFree;
    logic linkGo;
    logic linkRelease;
    logic linkDone;

    // shifter handshake
    logic shiftGo;
    logic shiftDone;
    logic [dataWidth-1:0] shiftDataOut;

    assign xferReady = (state == cIdle) && busFree;
    assign accept    = req.valid && xferReady;
    assign rsp.valid = rspValid;
    assign rsp.data  = wordReg;

    ////////////////////////////////////////////////////////////
    // transaction sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= cIdle;
            writeReg    <= 1'b0;
            linkGo      <= 1'b0;
            linkRelease <= 1'b0;
            shiftGo     <= 1'b0;
            rspValid    <= 1'b0;
        end else begin
            linkGo      <= 1'b0;   // all strobes are single pulses
            linkRelease <= 1'b0;
            shiftGo     <= 1'b0;
            rspValid    <= 1'b0;
            case (state)
                cIdle: begin
                    if (accept) begin
                        writeReg <= req.write;
                        linkGo   <= 1'b1;
                        state    <= cArbitrate;
                    end
                end
                cArbitrate: begin
                    if (linkDone) begin    // grant acknowledged
                        shiftGo <= 1'b1;
                        state   <= cFrame;
                    end
                end
                cFrame: state <= cData;    // shifter has taken the job
                cData: begin
                    if (shiftDone) begin
                        linkRelease <= 1'b1;
                        state       <= cRelease;
                    end
                end
                cRelease: begin
                    if (linkDone) begin
                        rspValid <= 1'b1;
                        state    <= cIdle;
                    end
                end
                default: state <= cIdle;
            endcase
        end
    end

    // word captured on accept, replaced by the shifter result
    always_ff @(posedge clk) begin
        if (accept) begin
            wordReg <= req.data;
        end else if (shiftDone) begin
            wordReg <= shiftDataOut;
        end
    end

    arbiterLink arbiterLink_i (
        .clk         (clk),
        .rstN        (rstN),
        .arbCont     (arbCont),
        .linkGo      (linkGo),
        .linkRelease (linkRelease),
        .busFree     (busFree),
        .linkDone    (linkDone),
        .arbSend     (arbSend)
    );

    frameShifter frameShifter_i (
        .clk          (clk),
        .rstN         (rstN),
        .shiftGo      (shiftGo),
        .shiftWrite   (writeReg),
        .shiftData    (wordReg),
        .rD           (rD),
        .ready        (ready),
        .shiftDone    (shiftDone),
        .shiftDataOut (shiftDataOut),
        .control      (control),
        .wrD          (wrD),
        .valid        (valid)
    );

endmodule

// File: busTransfer/frameShifter.sv
`timescale 1ns/1ps

module frameShifter import masterPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 shiftGo,
    input  logic                 shiftWrite,
    input  logic [dataWidth-1:0] shiftData,
    input  logic                 rD,
    input  logic                 ready,
    output logic                 shiftDone,
    output logic [dataWidth-1:0] shiftDataOut,
    output logic                 control,
    output logic                 wrD,
    output logic                 valid
);

    logic busy;
    logic isWrite;
    logic [controlLen-1:0] frame;
    logic [dataWidth-1:0] data;
    logic [shiftCntWidth-1:0] cnt;       // frame bits first, then data bits
    logic inFrame;
    logic lastBit;
    logic step;                          // data bit moves this cycle
    logic nextBit;

    assign inFrame = cnt < shiftCntWidth'(controlLen);
    assign lastBit = cnt == shiftCntWidth'(controlLen + dataWidth - 1);
    assign step    = busy && !inFrame && (isWrite || ready);
    // a write rotates, so the word is intact after the last bit
    assign nextBit = isWrite ? data[dataWidth-1] : rD;
    assign shiftDataOut = data;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            isWrite   <= 1'b0;
            cnt       <= '0;
            shiftDone <= 1'b0;
            control   <= 1'b0;
            wrD       <= 1'b0;
            valid     <= 1'b0;
        end else begin
            control   <= 1'b0;
            valid     <= 1'b0;
            shiftDone <= 1'b0;
            if (shiftGo) begin
                busy    <= 1'b1;
                isWrite <= shiftWrite;
                cnt     <= '0;
            end else if (busy && inFrame) begin
                control <= frame[controlLen-1];   // MSB first
                cnt     <= cnt + 1'b1;
            end else if (step) begin
                if (isWrite) begin
                    valid <= 1'b1;
                    wrD   <= data[dataWidth-1];
                end
                cnt <= cnt + 1'b1;
                if (lastBit) begin
                    busy      <= 1'b0;
                    shiftDone <= 1'b1;
                end
            end
        end
    end

    // frame and data shift registers
    always_ff @(posedge clk) begin
        if (shiftGo) begin
            frame <= {startBits, slaveId, shiftWrite};
            data  <= shiftData;
        end else if (busy && inFrame) begin
            frame <= frame << 1;
        end else if (step) begin
            data <= {data[dataWidth-2:0], nextBit};
        end
    end

endmodule

// File: common/masterPkg.sv
package masterPkg;

    ////////////////////////////////////////////////////////////
    // bus constants
    ////////////////////////////////////////////////////////////

    localparam int dataWidth = 8;
    localparam logic [dataWidth-1:0] seedWord = 8'h0A;   // loaded on start
    localparam logic [2:0] slaveId = 3'b100;             // only slave on the bus
    localparam logic [2:0] startBits = 3'b111;           // frame and request preamble

    localparam int controlLen = 7;   // start bits, slave id, r/w
    localparam int reqLen = 6;
    // three ones, top two id bits, trailing zero
    localparam logic [reqLen-1:0] reqPattern = {startBits, slaveId[2:1], 1'b0};

    // stands in for clock frequency times seconds
    localparam int displayCycles = 24;
    localparam int ackGap = 4;       // idle cycles after the acknowledge

    // counter widths
    localparam int linkCntWidth = 3;  // covers reqLen-1 and ackGap+1
    localparam int shiftCntWidth = $clog2(controlLen + dataWidth);
    localparam int dispCntWidth = $clog2(displayCycles);

    ////////////////////////////////////////////////////////////
    // state encodings and transfer structs
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {sIdle, sRead, sDisplay, sWrite, sEndCom} sessionState;
    typedef enum logic [2:0] {cIdle, cArbitrate, cFrame, cData, cRelease} commState;
    typedef enum logic [2:0] {lIdle, lRequest, lWaitGrant, lAck, lRelease} linkState;

    typedef struct packed {
        logic valid;
        logic write;                  // 1 = write, 0 = read
        logic [dataWidth-1:0] data;
    } xferReq;

    typedef struct packed {
        logic valid;                  // one-cycle pulse at the end
        logic [dataWidth-1:0] data;
    } xferRsp;

endpackage

// File: masterExternal.f
common/masterPkg.sv
busTransfer/arbiterLink.sv
busTransfer/frameShifter.sv
busTransfer/busTransfer.sv
rtl/sessionControl.sv
rtl/masterExternal.sv
sim/busModels.sv
sim/tbMasterExternal.sv

// File: rtl/masterExternal.sv
`timescale 1ns/1ps

module masterExternal import masterPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  logic                 eoc,
    input  logic                 rD,
    input  logic                 ready,
    input  logic                 arbCont,
    output logic                 doneCom,
    output logic                 disData,
    output logic                 control,
    output logic                 wrD,
    output logic                 valid,
    output logic                 arbSend,
    output logic [dataWidth-1:0] dataOut
);

    xferReq sessReq;     // session -> transfer
    xferRsp sessRsp;     // transfer -> session
    logic   xferReady;

    sessionControl sessionControl_i (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .eoc       (eoc),
        .xferReady (xferReady),
        .rsp       (sessRsp),
        .req       (sessReq),
        .dataOut   (dataOut),
        .disData   (disData),
        .doneCom   (doneCom)
    );

    busTransfer busTransfer_i (
        .clk       (clk),
        .rstN      (rstN),
        .req       (sessReq),
        .arbCont   (arbCont),
        .rD        (rD),
        .ready     (ready),
        .xferReady (xferReady),
        .rsp       (sessRsp),
        .arbSend   (arbSend),
        .control   (control),
        .wrD       (wrD),
        .valid     (valid)
    );

endmodule

// File: rtl/sessionControl.sv
`timescale 1ns/1ps

module sessionControl import masterPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  logic                 eoc,
    input  logic                 xferReady,
    input  xferRsp               rsp,
    output xferReq               req,
    output logic [dataWidth-1:0] dataOut,
    output logic                 disData,
    output logic                 doneCom
);

    sessionState state;
    logic [dataWidth-1:0] wordReg;       // last word read or seeded
    logic [dispCntWidth-1:0] dispCnt;    // display hold timer
    logic reqValid;
    logic reqWrite;

    assign req.valid = reqValid;
    assign req.write = reqWrite;
    assign req.data  = wordReg;

    // word stays on the display outputs, also after end of communication
    assign dataOut = wordReg;
    assign disData = (state == sDisplay);
    assign doneCom = (state == sEndCom);

    ////////////////////////////////////////////////////////////
    // session FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= sIdle;
            wordReg  <= '0;
            dispCnt  <= '0;
            reqValid <= 1'b0;
            reqWrite <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (start && !eoc) begin
                        wordReg <= seedWord;
                        state   <= sDisplay;
                    end else if (eoc) begin
                        state <= sEndCom;
                    end else begin
                        reqValid <= 1'b1;    // default loop starts with a read
                        reqWrite <= 1'b0;
                        state    <= sRead;
                    end
                end
                sRead: begin
                    if (reqValid) begin
                        if (xferReady) begin
                            reqValid <= 1'b0;        // taken, wait for the word
                        end else if (start) begin
                            reqValid <= 1'b0;
                            wordReg  <= seedWord;    // seed replaces the pending read
                            state    <= sDisplay;
                        end else if (eoc) begin
                            reqValid <= 1'b0;
                            state    <= sEndCom;
                        end
                    end else if (rsp.valid) begin
                        wordReg <= rsp.data;
                        state   <= sDisplay;
                    end
                end
                sDisplay: begin
                    if (dispCnt == dispCntWidth'(displayCycles - 1)) begin
                        dispCnt  <= '0;
                        reqValid <= 1'b1;    // write the shown word back
                        reqWrite <= 1'b1;
                        state    <= sWrite;
                    end else begin
                        dispCnt <= dispCnt + 1'b1;
                    end
                end
                sWrite: begin
                    if (reqValid) begin
                        if (xferReady) begin
                            reqValid <= 1'b0;
                        end else if (eoc) begin
                            reqValid <= 1'b0;
                            state    <= sEndCom;
                        end
                    end else if (rsp.valid) begin
                        reqValid <= 1'b1;    // back to reading
                        reqWrite <= 1'b0;
                        state    <= sRead;
                    end
                end
                sEndCom: state <= sEndCom;   // only reset leaves
                default: state <= sIdle;
            endcase
        end
    end

endmodule

// File: sim/busModels.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// arbiter model: captures the request, grants after a delay
////////////////////////////////////////////////////////////

module arbiterModel import masterPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              arbSend,
    input  logic              busy,          // bus held by another board
    input  logic [7:0]        grantDelay,
    output logic              arbCont,
    output logic              grant,
    output int                reqCount,
    output int                relCount,
    output logic [reqLen-1:0] lastReq
);

    logic capturing;
    logic inXfer;                  // request seen, release still to come
    logic [reqLen-1:0] reqBits;
    logic [3:0] history;           // earlier arbSend samples
    int bitCnt;
    int delayCnt;

    assign arbCont = grant | busy;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            capturing <= 1'b0;
            inXfer    <= 1'b0;
            reqBits   <= '0;
            history   <= '0;
            bitCnt    <= 0;
            delayCnt  <= 0;
            grant     <= 1'b0;
            reqCount  <= 0;
            relCount  <= 0;
            lastReq   <= '0;
        end else begin
            history <= {history[2:0], arbSend};
            if (!inXfer && (capturing || arbSend)) begin
                reqBits   <= {reqBits[reqLen-2:0], arbSend};
                bitCnt    <= bitCnt + 1;
                capturing <= 1'b1;
                if (bitCnt == reqLen - 1) begin
                    lastReq   <= {reqBits[reqLen-2:0], arbSend};
                    reqCount  <= reqCount + 1;
                    capturing <= 1'b0;
                    bitCnt    <= 0;
                    inXfer    <= 1'b1;
                    delayCnt  <= 0;
                end
            end else if (inXfer && !grant) begin
                if (delayCnt >= grantDelay) begin
                    grant <= 1'b1;
                end else begin
                    delayCnt <= delayCnt + 1;
                end
            end else if (grant && {history, arbSend} == 5'b10110) begin
                grant    <= 1'b0;          // high hold, then 0 1 1 0
                inXfer   <= 1'b0;
                relCount <= relCount + 1;
            end
        end
    end

endmodule

////////////////////////////////////////////////////////////
// slave model: logs frames and written bits, serves reads
////////////////////////////////////////////////////////////

module slaveModel import masterPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  control,
    input  logic                  valid,
    input  logic                  wrD,
    input  logic [dataWidth-1:0]  word,       // served on a read
    output logic                  rD,
    output logic                  ready,
    output int                    frameCount,
    output int                    wrCount,
    output logic [controlLen-1:0] lastFrame,
    output logic [dataWidth-1:0]  wrWord
);

    logic [controlLen-1:0] frameBits;
    logic [31:0] rngState;
    logic serving;
    int frameCnt;
    int bitIdx;
    int nextIdx;

    // a bit is gone once the master has seen ready with it
    assign nextIdx = bitIdx + (ready ? 1 : 0);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rD         <= 1'b0;
            ready      <= 1'b0;
            frameBits  <= '0;
            frameCnt   <= 0;
            frameCount <= 0;
            lastFrame  <= '0;
            wrCount    <= 0;
            wrWord     <= '0;
            serving    <= 1'b0;
            bitIdx     <= 0;
            rngState   <= 32'd80221;
        end else begin
            if (frameCnt != 0 || control) begin    // frames open with a start one
                frameBits <= {frameBits[controlLen-2:0], control};
                frameCnt  <= frameCnt + 1;
                if (frameCnt == controlLen - 1) begin
                    lastFrame  <= {frameBits[controlLen-2:0], control};
                    frameCount <= frameCount + 1;
                    frameCnt   <= 0;
                    serving    <= !control;        // read frame ends in 0
                    bitIdx     <= 0;
                end
            end
            if (valid) begin
                wrWord  <= {wrWord[dataWidth-2:0], wrD};
                wrCount <= wrCount + 1;
            end
            if (serving) begin
                if (nextIdx == dataWidth) begin
                    serving <= 1'b0;
                    ready   <= 1'b0;
                end else begin
                    bitIdx   <= nextIdx;
                    ready    <= (rngState[1:0] != 2'b00);   // roughly one gap in four
                    rD       <= word[dataWidth-1-nextIdx];
                    rngState <= xorshift(rngState);
                end
            end
        end
    end

endmodule

// File: sim/tbMasterExternal.sv
`timescale 1ns/1ps

module tbMasterExternal import masterPkg::*; ();

    typedef struct packed {
        logic doStart;
        logic doEoc;
        logic [dataWidth-1:0] slaveWord;
        logic [7:0] grantDelay;
        logic [dataWidth-1:0] expDisp;
        logic [dataWidth-1:0] expWrite;
        logic [controlLen-1:0] expFrame;    // frame of the row's first transaction
    } testRow;

    logic clk;
    logic rstN;
    logic start;
    logic eoc;
    logic busy;
    logic [7:0] grantDelay;
    logic [dataWidth-1:0] slaveWord;
    logic rD;
    logic ready;
    logic arbCont;
    logic grant;
    logic doneCom;
    logic disData;
    logic control;
    logic wrD;
    logic valid;
    logic arbSend;
    logic [dataWidth-1:0] dataOut;
    logic [reqLen-1:0] lastReq;
    logic [controlLen-1:0] lastFrame;
    logic [dataWidth-1:0] wrWord;
    int reqCount;
    int relCount;
    int frameCount;
    int wrCount;

    testRow rows [$];
    int xfers = 0;          // transactions finished
    int writes = 0;
    int errorCount = 0;
    int testsRun = 0;
    int failedTests = 0;
    int cycleCount = 0;
    int timeoutLimit = 0;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    masterExternal masterExternal_i (
        .clk(clk), .rstN(rstN), .start(start), .eoc(eoc), .rD(rD), .ready(ready),
        .arbCont(arbCont), .doneCom(doneCom), .disData(disData), .control(control),
        .wrD(wrD), .valid(valid), .arbSend(arbSend), .dataOut(dataOut)
    );

    arbiterModel arbiterModel_i (
        .clk(clk), .rstN(rstN), .arbSend(arbSend), .busy(busy), .grantDelay(grantDelay),
        .arbCont(arbCont), .grant(grant), .reqCount(reqCount), .relCount(relCount),
        .lastReq(lastReq)
    );

    slaveModel slaveModel_i (
        .clk(clk), .rstN(rstN), .control(control), .valid(valid), .wrD(wrD),
        .word(slaveWord), .rD(rD), .ready(ready), .frameCount(frameCount),
        .wrCount(wrCount), .lastFrame(lastFrame), .wrWord(wrWord)
    );

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errorCount++;
        end
    endtask

    always @(posedge clk) begin
        if (rstN && control) begin
            assert (grant) else begin
                $display("control frame started before the arbiter granted the bus");
                errorCount++;
            end
        end
    end

    // run limit, two transactions per row
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("timeout, the run did not finish within %0d cycles", timeoutLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic checkIdleOutputs();
        checkValue("arbSend", arbSend, 0);
        checkValue("control", control, 0);
        checkValue("wrD", wrD, 0);
        checkValue("valid", valid, 0);
        checkValue("disData", disData, 0);
        checkValue("doneCom", doneCom, 0);
        checkValue("dataOut", dataOut, 0);
    endtask

    task automatic awaitFrame(input logic [controlLen-1:0] expFrame);
        while (reqCount == xfers) @(posedge clk);
        checkValue("arbSend request", lastReq, 6'b111100);    // three ones, id 10, zero
        while (frameCount == xfers) @(posedge clk);
        checkValue("control frame", lastFrame, expFrame);
    endtask

    // the arbiter model counts a release only after 0 1 1 0 on arbSend
    task automatic awaitRelease();
        while (relCount == xfers) @(posedge clk);
        xfers++;
    endtask

    task automatic checkDisplay(input logic [dataWidth-1:0] expWord);
        int n;
        n = 0;
        while (!disData) @(posedge clk);
        while (disData) begin
            checkValue("dataOut", dataOut, expWord);
            n++;
            @(posedge clk);
        end
        checkValue("disData cycles", n, displayCycles);
    endtask

    task automatic checkEndCom(input logic [dataWidth-1:0] lastWord);
        int framesBefore;
        int reqBefore;
        while (!doneCom) @(posedge clk);
        busy <= 1'b0;                        // free bus, master must stay quiet
        framesBefore = frameCount;
        reqBefore = reqCount;
        repeat (40) begin
            @(posedge clk);
            checkValue("doneCom", doneCom, 1);
            checkValue("dataOut", dataOut, lastWord);
            checkValue("control", control, 0);
        end
        checkValue("frame count", frameCount, framesBefore);
        checkValue("request count", reqCount, reqBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // test table and row sequence
    ////////////////////////////////////////////////////////////

    task automatic loadTable();
        // start, eoc, slave word, grant delay, display, written, first frame
        rows.push_back({1'b0, 1'b0, 8'hA5, 8'd3, 8'hA5, 8'hA5, 7'b1111000});
        rows.push_back({1'b0, 1'b0, 8'h3C, 8'd0, 8'h3C, 8'h3C, 7'b1111000});
        rows.push_back({1'b1, 1'b0, 8'h77, 8'd5, 8'h0A, 8'h0A, 7'b1111001});
        rows.push_back({1'b0, 1'b0, 8'hC3, 8'd9, 8'hC3, 8'hC3, 7'b1111000});
        rows.push_back({1'b0, 1'b0, 8'h01, 8'd2, 8'h01, 8'h01, 7'b1111000});
        rows.push_back({1'b0, 1'b1, 8'hFF, 8'd0, 8'h01, 8'h00, 7'b0000000});
    endtask

    task automatic runRow(input int i);
        testRow r;
        r = rows[i];
        slaveWord  <= r.slaveWord;
        grantDelay <= r.grantDelay;
        if (r.doStart || r.doEoc) begin
            repeat (4) @(posedge clk);       // read request now waits on the busy bus
            if (r.doEoc) begin
                eoc <= 1'b1;
            end else begin
                start <= 1'b1;
            end
            @(posedge clk);
            start <= 1'b0;
        end
        if (r.doEoc) begin
            checkEndCom(r.expDisp);
        end else begin
            if (!r.doStart) begin
                awaitFrame(r.expFrame);
                awaitRelease();
            end
            busy <= 1'b0;
            checkDisplay(r.expDisp);
            awaitFrame(r.doStart ? r.expFrame : 7'b1111001);
            while (wrCount < dataWidth * (writes + 1)) @(posedge clk);
            checkValue("wrD word", wrWord, r.expWrite);
            writes++;
            // keep the bus busy across this release for a start or eoc row
            if (i + 1 < rows.size() && (rows[i + 1].doStart || rows[i + 1].doEoc)) begin
                busy <= 1'b1;
            end
            awaitRelease();
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errorCount == errBefore) begin
            $display("test %-8s passed", name);
        end else begin
            $display("test %-8s failed with %0d errors", name, errorCount - errBefore);
            failedTests++;
        end
        testsRun++;
    endtask

    initial begin
        int errBefore;
        int maxDelay;
        rstN       <= 1'b0;
        start      <= 1'b0;
        eoc        <= 1'b0;
        busy       <= 1'b0;
        slaveWord  <= '0;
        grantDelay <= '0;
        loadTable();
        maxDelay = 0;
        foreach (rows[k]) begin
            if (rows[k].grantDelay > maxDelay) begin
                maxDelay = rows[k].grantDelay;
            end
        end
        timeoutLimit = rows.size() * 2 * (displayCycles + maxDelay + 64);

        errBefore = errorCount;
        repeat (16) @(posedge clk);
        checkIdleOutputs();                  // still in reset
        rstN <= 1'b1;
        @(posedge clk);
        checkIdleOutputs();
        reportTest("reset", errBefore);

        for (int i = 0; i < rows.size(); i++) begin
            errBefore = errorCount;
            runRow(i);
            reportTest($sformatf("row %0d", i), errBefore);
        end

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 testsRun, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
